//--- verilog/cache_geom_pkg.sv
package cache_geom_pkg;

    // Four sets of four ways, 16 bytes per line.
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 4;
    localparam int LINE_BYTES = 16;

    typedef logic [7:0]   tag_t;
    typedef logic [1:0]   index_t;
    typedef logic [1:0]   way_t;
    typedef logic [127:0] line_t;
    typedef logic [15:0]  mask_t;

    // Physical address, 14 bits.
    typedef struct packed {
        tag_t       tag;    // Bits 13:6.
        index_t     index;  // Bits 5:4.
        logic [3:0] offset;
    } addr_t;

    // Age 0 is the most recent way, age 3 the LRU one.
    typedef struct packed {
        logic       valid;
        logic       dirty;
        logic [1:0] age;
    } way_meta_t;

endpackage

//--- verilog/cache_msg_pkg.sv
package cache_msg_pkg;

    import cache_geom_pkg::*;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    typedef enum logic {
        MEM_FILL,
        MEM_WRITEBACK
    } mem_op_e;

    typedef struct packed {
        cache_op_e  op;
        addr_t      addr;
        logic [3:0] id;
        line_t      data;
        mask_t      mask;   // One bit per data byte.
    } cache_req_t;

    typedef struct packed {
        logic [3:0] id;
        logic       hit;
        line_t      line;   // Whole line after the access.
    } cache_resp_t;

    typedef struct packed {
        mem_op_e op;
        tag_t    tag;
        index_t  index;
        line_t   data;      // Only meaningful on a writeback.
    } mem_req_t;

    // Lookup result, consumed by the data stage.
    typedef struct packed {
        cache_op_e  op;
        logic [3:0] id;
        index_t     index;
        way_t       way;
        logic       hit;
        line_t      data;
        mask_t      mask;
        logic       fill;   // Install the held fill line.
    } lookup_t;

endpackage

//--- verilog/cache_req_decode.sv
`timescale 1ns/1ps

module cache_req_decode import cache_msg_pkg::*; #(
    parameter int REQ_CREDITS = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  cache_req_t req,
    output logic       req_credit,
    output logic       dec_valid,
    output cache_req_t dec,
    input  logic       lookup_ready
);

    localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
    localparam int CNT_W = $clog2(REQ_CREDITS + 1);

    cache_req_t       entries [REQ_CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] entry_count;
    logic             pop;

    // Oldest entry is always presented.
    assign dec_valid = (entry_count != '0);
    assign dec       = entries[rd_ptr];
    assign pop       = dec_valid && lookup_ready;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            entries[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            entry_count <= '0;
            req_credit  <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            entry_count <= entry_count + CNT_W'(req_valid) - CNT_W'(pop);
            req_credit  <= pop;  // One credit back per departed entry.
        end
    end

endmodule

//--- verilog/cache_tag_lookup.sv
`timescale 1ns/1ps

module cache_tag_lookup import cache_geom_pkg::*, cache_msg_pkg::*; #(
    parameter int MEM_CREDITS = 2
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       dec_valid,
    input  cache_req_t dec,
    output logic       lookup_ready,
    input  logic       result_ready,
    output logic       lk_valid,
    output lookup_t    lk,
    input  line_t      victim_line,
    output way_t       victim_sel,
    output index_t     victim_index,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_credit,
    input  logic       mem_fill_valid
);

    localparam int MEM_CW = $clog2(MEM_CREDITS + 1);

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        COMPLETE
    } miss_state_e;

    miss_state_e       state;
    tag_t              tags [NUM_SETS][NUM_WAYS];
    way_meta_t         meta [NUM_SETS][NUM_WAYS];
    logic [MEM_CW-1:0] mem_credits;
    way_t              miss_way;
    index_t            idx;
    logic [NUM_WAYS-1:0] hit_vec;
    logic              hit_any;
    way_t              hit_way;
    way_t              victim_way;
    logic              inv_found;
    way_t              acc_way;
    logic [1:0]        acc_age;
    logic              lk_adv;
    logic              take;
    logic              mem_send;

    assign idx = dec.addr.index;

    // Parallel tag compare.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = meta[idx][w].valid && (tags[idx][w] == dec.addr.tag);
            if (hit_vec[w]) hit_way = way_t'(w);
        end
        hit_any = |hit_vec;
    end

    // Lowest invalid way first, otherwise the oldest one.
    always_comb begin
        victim_way = '0;
        inv_found  = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!inv_found && !meta[idx][w].valid) begin
                victim_way = way_t'(w);
                inv_found  = 1'b1;
            end
        end
        if (!inv_found) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (meta[idx][w].age == 2'd3) victim_way = way_t'(w);
            end
        end
    end

    assign lk_adv       = !lk_valid || result_ready;
    assign lookup_ready = lk_adv && ((state == IDLE && hit_any) || state == COMPLETE);
    assign take         = dec_valid && lookup_ready;
    assign acc_way      = (state == COMPLETE) ? miss_way : hit_way;
    assign acc_age      = meta[idx][acc_way].age;

    assign victim_sel   = miss_way;
    assign victim_index = idx;

    assign mem_req_valid = (state == WRITEBACK || state == FILL_REQ) && (mem_credits != '0);
    assign mem_send      = mem_req_valid;
    assign mem_req.op    = (state == WRITEBACK) ? MEM_WRITEBACK : MEM_FILL;
    assign mem_req.tag   = (state == WRITEBACK) ? tags[idx][miss_way] : dec.addr.tag;
    assign mem_req.index = idx;
    assign mem_req.data  = (state == WRITEBACK) ? victim_line : '0;

    // Miss sequencer. A miss starts only once the lk register has drained.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            miss_way <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (dec_valid && !hit_any && !lk_valid) begin
                        miss_way <= victim_way;
                        if (meta[idx][victim_way].valid && meta[idx][victim_way].dirty)
                            state <= WRITEBACK;
                        else
                            state <= FILL_REQ;
                    end
                end
                WRITEBACK: if (mem_send) state <= FILL_REQ;
                FILL_REQ:  if (mem_send) state <= FILL_WAIT;
                FILL_WAIT: if (mem_fill_valid) state <= COMPLETE;
                COMPLETE:  if (take) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_credits <= MEM_CW'(MEM_CREDITS);
        end else begin
            mem_credits <= mem_credits + MEM_CW'(mem_credit) - MEM_CW'(mem_send);
        end
    end

    // Ages start as a permutation and stay one.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    meta[s][w].valid <= 1'b0;
                    meta[s][w].dirty <= 1'b0;
                    meta[s][w].age   <= 2'(w);
                end
            end
        end else if (take) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (way_t'(w) == acc_way) begin
                    meta[idx][w].valid <= 1'b1;
                    meta[idx][w].dirty <= (dec.op == OP_WRITE) ||
                                          (state == IDLE && meta[idx][w].dirty);
                    meta[idx][w].age   <= 2'd0;
                end else if (meta[idx][w].age < acc_age) begin
                    meta[idx][w].age <= meta[idx][w].age + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && state == COMPLETE) begin
            tags[idx][miss_way] <= dec.addr.tag;  // Install the new tag.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lk_valid <= 1'b0;
        end else if (take) begin
            lk_valid <= 1'b1;
        end else if (result_ready) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            lk.op    <= dec.op;
            lk.id    <= dec.id;
            lk.index <= idx;
            lk.way   <= acc_way;
            lk.hit   <= (state == IDLE);
            lk.data  <= dec.data;
            lk.mask  <= dec.mask;
            lk.fill  <= (state == COMPLETE);
        end
    end

endmodule

//--- verilog/cache_line_result.sv
`timescale 1ns/1ps

module cache_line_result import cache_geom_pkg::*, cache_msg_pkg::*; #(
    parameter int RESP_CREDITS = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        lk_valid,
    input  lookup_t     lk,
    output logic        result_ready,
    input  logic        mem_fill_valid,
    input  line_t       mem_fill_data,
    input  way_t        victim_sel,
    input  index_t      victim_index,
    output line_t       victim_line,
    output logic        resp_valid,
    output cache_resp_t resp,
    input  logic        resp_credit
);

    localparam int CRED_W = $clog2(RESP_CREDITS + 1);

    line_t             data_mem [NUM_SETS][NUM_WAYS];
    line_t             fill_line;
    line_t             base_line;
    line_t             new_line;
    logic              out_full;
    logic              take;
    logic              send;
    logic [CRED_W-1:0] resp_credits;

    assign victim_line = data_mem[victim_index][victim_sel];

    assign resp_valid   = out_full && (resp_credits != '0);
    assign send         = resp_valid;
    assign result_ready = !out_full || (resp_credits != '0);
    assign take         = lk_valid && result_ready;

    // Stored or filled line, with write bytes merged in.
    always_comb begin
        base_line = lk.fill ? fill_line : data_mem[lk.index][lk.way];
        new_line  = base_line;
        if (lk.op == OP_WRITE) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (lk.mask[b]) new_line[8*b +: 8] = lk.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_fill_valid) begin
            fill_line <= mem_fill_data;  // Held until the fill lk arrives.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_mem[lk.index][lk.way] <= new_line;
            resp.id   <= lk.id;
            resp.hit  <= lk.hit;
            resp.line <= new_line;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_full <= 1'b0;
        end else if (take) begin
            out_full <= 1'b1;
        end else if (send) begin
            out_full <= 1'b0;
        end
    end

    // Response credits.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_credits <= CRED_W'(RESP_CREDITS);
        end else begin
            resp_credits <= resp_credits + CRED_W'(resp_credit) - CRED_W'(send);
        end
    end

endmodule

//--- verilog/cache_stage_top.sv
`timescale 1ns/1ps

module cache_stage_top import cache_geom_pkg::*, cache_msg_pkg::*; #(
    parameter int REQ_CREDITS  = 4,
    parameter int RESP_CREDITS = 2,
    parameter int MEM_CREDITS  = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req_valid,
    input  cache_req_t  req,
    output logic        req_credit,
    output logic        resp_valid,
    output cache_resp_t resp,
    input  logic        resp_credit,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_credit,
    input  logic        mem_fill_valid,
    input  line_t       mem_fill_data
);

    logic       dec_valid;
    cache_req_t dec;
    logic       lookup_ready;
    logic       lk_valid;
    lookup_t    lk;
    logic       result_ready;
    line_t      victim_line;
    way_t       victim_sel;
    index_t     victim_index;

    cache_req_decode #(.REQ_CREDITS(REQ_CREDITS)) req_decode_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req          (req),
        .req_credit   (req_credit),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .lookup_ready (lookup_ready)
    );

    cache_tag_lookup #(.MEM_CREDITS(MEM_CREDITS)) tag_lookup_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .lookup_ready   (lookup_ready),
        .result_ready   (result_ready),
        .lk_valid       (lk_valid),
        .lk             (lk),
        .victim_line    (victim_line),
        .victim_sel     (victim_sel),
        .victim_index   (victim_index),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_credit     (mem_credit),
        .mem_fill_valid (mem_fill_valid)
    );

    // Fill data goes straight to the data stage.
    cache_line_result #(.RESP_CREDITS(RESP_CREDITS)) line_result_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .lk_valid       (lk_valid),
        .lk             (lk),
        .result_ready   (result_ready),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill_data  (mem_fill_data),
        .victim_sel     (victim_sel),
        .victim_index   (victim_index),
        .victim_line    (victim_line),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .resp_credit    (resp_credit)
    );

endmodule

//--- test/cache_tb_assertions.sv
`timescale 1ns/1ps

module cache_tb_assertions #(
    parameter int RESP_CREDITS = 2,
    parameter int MEM_CREDITS  = 2
) (
    input logic clk,
    input logic arst_n,
    input logic req_valid,
    input logic req_credit,
    input logic dec_valid,
    input logic lk_valid,
    input logic resp_valid,
    input logic resp_credit,
    input logic mem_req_valid,
    input logic mem_credit,
    input logic buf_full
);

    int resp_held;
    int mem_held;
    int fail_count = 0;

    // Credits held by the cache, counted from its pins.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_held <= RESP_CREDITS;
            mem_held  <= MEM_CREDITS;
        end else begin
            resp_held <= resp_held + int'(resp_credit) - int'(resp_valid);
            mem_held  <= mem_held + int'(mem_credit) - int'(mem_req_valid);
        end
    end

    resp_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> resp_held > 0)
        else begin
            fail_count++;
            $error("resp_valid raised with no response credit");
        end

    mem_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> mem_held > 0)
        else begin
            fail_count++;
            $error("mem_req_valid raised with no memory credit");
        end

    // Sender must respect its credits.
    no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> !buf_full)
        else begin
            fail_count++;
            $error("request arrived while the decode buffer was full");
        end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !(req_credit || dec_valid || lk_valid || resp_valid || mem_req_valid))
        else begin
            fail_count++;
            $error("valid output high during reset");
        end

endmodule

bind cache_stage_top cache_tb_assertions #(
    .RESP_CREDITS (RESP_CREDITS),
    .MEM_CREDITS  (MEM_CREDITS)
) assertions_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .req_valid      (req_valid),
    .req_credit     (req_credit),
    .dec_valid      (dec_valid),
    .lk_valid       (lk_valid),
    .resp_valid     (resp_valid),
    .resp_credit    (resp_credit),
    .mem_req_valid  (mem_req_valid),
    .mem_credit     (mem_credit),
    .buf_full       (req_decode_inst.entry_count == REQ_CREDITS)
);

//--- test/cache_tb.sv
`timescale 1ns/1ps

module cache_tb import cache_geom_pkg::*, cache_msg_pkg::*;;

    localparam int TOTAL_REQS = 327;
    localparam int CYCLE_LIMIT = 40 * TOTAL_REQS + 200;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        req_valid = 1'b0;
    cache_req_t  req = '0;
    logic        req_credit;
    logic        resp_valid;
    cache_resp_t resp;
    logic        resp_credit = 1'b0;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_credit = 1'b0;
    logic        mem_fill_valid = 1'b0;
    line_t       mem_fill_data = '0;

    integer     seed = 71247;
    int         errors = 0;
    int         cyc = 0;
    int         req_cred = 4;
    int         pend_resp = 0;
    int         pend_mem = 0;
    int         mem_dly = 0;
    int         fill_cnt = 0;
    int         resp_count = 0;
    int         meas_cycle = 0;
    logic       hold_resp = 1'b0;
    logic       rand_mode = 1'b0;
    logic       meas_on = 1'b0;
    logic [3:0] meas_id = '0;
    logic [3:0] next_id = '0;
    logic [9:0] fill_addr = '0;

    line_t      mem [1024];             // Indexed by {tag, index}.
    line_t      m_mem [1024];           // Memory as the model sees it.
    tag_t       m_tag [NUM_SETS][NUM_WAYS];
    line_t      m_data [NUM_SETS][NUM_WAYS];
    way_meta_t  m_meta [NUM_SETS][NUM_WAYS];
    logic       exp_wb;
    logic [9:0] exp_wb_addr;
    line_t      exp_wb_data;

    cache_req_t stim_q [$];
    cache_req_t exp_q [$];
    mem_req_t   wb_q [$];

    cache_stage_top cache_stage_top_inst (.*);

    always #20 clk = ~clk;

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic line_t mem_pattern(logic [9:0] la);
        line_t p;
        for (int w = 0; w < 8; w++) p[16*w +: 16] = {3'(w), 3'b101, la};
        return p;
    endfunction

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Model cache picks the hit way, else the lowest invalid way, else age 3.
    function automatic cache_resp_t ref_access(cache_req_t r);
        cache_resp_t e;
        int          w;
        index_t      s;
        logic [1:0]  a;
        s = r.addr.index;
        w = -1;
        exp_wb = 1'b0;
        for (int i = 0; i < NUM_WAYS; i++)
            if (m_meta[s][i].valid && m_tag[s][i] == r.addr.tag) w = i;
        e.hit = (w >= 0);
        if (w < 0) begin
            for (int i = NUM_WAYS - 1; i >= 0; i--) if (!m_meta[s][i].valid) w = i;
            if (w < 0) begin
                for (int i = 0; i < NUM_WAYS; i++) if (m_meta[s][i].age == 2'd3) w = i;
                if (m_meta[s][w].dirty) begin
                    exp_wb      = 1'b1;
                    exp_wb_addr = {m_tag[s][w], s};
                    exp_wb_data = m_data[s][w];
                    m_mem[exp_wb_addr] = m_data[s][w];
                end
            end
            m_data[s][w] = m_mem[{r.addr.tag, s}];
            m_tag[s][w] = r.addr.tag;
            m_meta[s][w].valid = 1'b1;
            m_meta[s][w].dirty = 1'b0;
        end
        if (r.op == OP_WRITE) begin
            for (int b = 0; b < LINE_BYTES; b++)
                if (r.mask[b]) m_data[s][w][8*b +: 8] = r.data[8*b +: 8];
            m_meta[s][w].dirty = 1'b1;
        end
        a = m_meta[s][w].age;
        for (int i = 0; i < NUM_WAYS; i++)
            if (i != w && m_meta[s][i].age < a) m_meta[s][i].age++;
        m_meta[s][w].age = 2'd0;
        e.id = r.id;
        e.line = m_data[s][w];
        return e;
    endfunction

    task automatic push_req(cache_op_e op, tag_t tag, index_t idx, line_t data, mask_t mask);
        cache_req_t r;
        r.op = op;
        r.addr = {tag, idx, 4'h0};
        r.id = next_id;
        r.data = data;
        r.mask = mask;
        next_id++;
        stim_q.push_back(r);
    endtask

    task automatic wait_idle();
        while (stim_q.size() > 0 || exp_q.size() > 0 || pend_resp > 0 || pend_mem > 0
               || fill_cnt > 0 || req_cred != 4) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    // Request driver, paced by the credits the testbench holds.
    always @(posedge clk) begin : drive
        logic       sent;
        cache_req_t r;
        sent = 1'b0;
        req_valid <= 1'b0;
        if (arst_n && stim_q.size() > 0 && req_cred > 0 && !(rand_mode && rnd(3) == 0)) begin
            r = stim_q.pop_front();
            sent = 1'b1;
            req <= r;
            req_valid <= 1'b1;
            exp_q.push_back(r);
            if (meas_on && r.id == meas_id) meas_cycle = cyc;
        end
        req_cred <= req_cred + int'(req_credit) - int'(sent);
    end

    always @(posedge clk) begin : resp_credits
        logic give;
        give = pend_resp > 0 && !hold_resp && (!rand_mode || rnd(3) == 0);
        resp_credit <= give;
        pend_resp <= pend_resp + int'(resp_valid) - int'(give);
    end

    // Memory model with credit return and delayed fills.
    always @(posedge clk) begin : memory
        logic give;
        give = pend_mem > 0 && mem_dly == 0;
        mem_credit <= give;
        mem_fill_valid <= 1'b0;
        if (give) mem_dly <= rnd(4);
        else if (mem_dly > 0) mem_dly <= mem_dly - 1;
        pend_mem <= pend_mem + int'(mem_req_valid) - int'(give);
        if (fill_cnt == 1) begin
            mem_fill_valid <= 1'b1;
            mem_fill_data <= mem[fill_addr];
        end
        if (fill_cnt > 0) fill_cnt <= fill_cnt - 1;
        if (mem_req_valid) begin
            if (mem_req.op == MEM_WRITEBACK) begin
                mem[{mem_req.tag, mem_req.index}] <= mem_req.data;
                wb_q.push_back(mem_req);
            end else begin
                fill_addr <= {mem_req.tag, mem_req.index};
                fill_cnt <= 2 + rnd(5);
            end
        end
    end

    always @(posedge clk) begin : compare
        cache_req_t  r;
        cache_resp_t e;
        mem_req_t    w;
        if (resp_valid) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Response id %0d arrived with no request outstanding", resp.id);
            end else begin
                r = exp_q.pop_front();
                e = ref_access(r);
                check_val("resp.id", 128'(resp.id), 128'(e.id));
                check_val("resp.hit", 128'(resp.hit), 128'(e.hit));
                check_val("resp.line", resp.line, e.line);
                if (exp_wb) begin
                    if (wb_q.size() == 0) begin
                        errors++;
                        $display("Expected writeback of line %h never reached memory",
                                 exp_wb_addr);
                    end else begin
                        w = wb_q.pop_front();
                        check_val("wb_addr", 128'({w.tag, w.index}), 128'(exp_wb_addr));
                        check_val("wb_data", w.data, exp_wb_data);
                    end
                end
                if (meas_on && resp.id == meas_id) begin
                    check_val("resp_latency", 128'(cyc - meas_cycle - 1), 128'(3));
                    meas_on = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cyc <= cyc + 1;
        if (cyc > CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", errors + 1);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int held;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = mem_pattern(10'(a));
            m_mem[a] = mem_pattern(10'(a));
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) m_meta[s][w] = {1'b0, 1'b0, 2'(w)};
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        // Fill one set, then hit on all four.
        for (int t = 1; t <= 4; t++) push_req(OP_READ, 8'(t), 2'd0, '0, '0);
        for (int t = 1; t <= 4; t++) push_req(OP_READ, 8'(t), 2'd0, '0, '0);
        wait_idle();
        push_req(OP_WRITE, 8'd2, 2'd0, {8{16'hbeef}}, 16'h00f0);
        push_req(OP_READ, 8'd2, 2'd0, '0, '0);
        wait_idle();
        // Make tag 2 the dirty LRU way, evict it, then read it back.
        push_req(OP_READ, 8'd3, 2'd0, '0, '0);
        push_req(OP_READ, 8'd4, 2'd0, '0, '0);
        push_req(OP_READ, 8'd1, 2'd0, '0, '0);
        push_req(OP_READ, 8'd5, 2'd0, '0, '0);
        push_req(OP_READ, 8'd2, 2'd0, '0, '0);
        wait_idle();
        hold_resp = 1'b1;
        held = resp_count;
        for (int i = 0; i < 10; i++) push_req(OP_READ, 8'd4, 2'd0, '0, '0);
        repeat (40) @(posedge clk);
        check_val("resp_during_hold", 128'(resp_count - held), 128'(2));
        check_val("req_cred_during_hold", 128'(req_cred), 128'(0));
        hold_resp = 1'b0;
        wait_idle();
        rand_mode = 1'b1;
        for (int i = 0; i < 300; i++) begin
            push_req(cache_op_e'(rnd(2)), 8'(8'h10 + rnd(12)), 2'(rnd(4)),
                     {$random(seed), $random(seed), $random(seed), $random(seed)},
                     16'($random(seed)));
        end
        wait_idle();
        rand_mode = 1'b0;
        // Bring tag 5 back into set 0 so that the timed read hits.
        push_req(OP_READ, 8'd5, 2'd0, '0, '0);
        wait_idle();
        meas_id = next_id;
        meas_on = 1'b1;
        push_req(OP_READ, 8'd5, 2'd0, '0, '0);
        wait_idle();
        if (meas_on) begin
            errors++;
            $display("Latency request never produced a response");
        end
        if (wb_q.size() != 0) begin
            errors += wb_q.size();
            $display("Memory saw %0d writebacks the model did not expect", wb_q.size());
        end
        if (cache_stage_top_inst.assertions_inst.fail_count != 0) begin
            errors += cache_stage_top_inst.assertions_inst.fail_count;
            $display("Bound assertions failed %0d times",
                     cache_stage_top_inst.assertions_inst.fail_count);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
verilog/cache_geom_pkg.sv
verilog/cache_msg_pkg.sv
verilog/cache_req_decode.sv
verilog/cache_tag_lookup.sv
verilog/cache_line_result.sv
verilog/cache_stage_top.sv
test/cache_tb_assertions.sv
test/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run; pass only if the testbench prints its pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f tb.f -o cache_sim \
    && ./obj_dir/cache_sim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
